// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_tb;
   import lsu_op_pkg::*;

   typedef struct packed {
      logic        edtm;
      logic        edpf;
      logic        ealign;
      logic        chk_dout;   // Loads without exception only
      logic [31:0] vaddr;
      logic [31:0] dout;
   } exp_t;

   localparam int N_INIT = 256;
   localparam int N_MIS  = 16;
   localparam int N_REQ  = N_INIT + 2*N_MIS + 300 + 300 + 200 + 200;

   // Mapped vpns, the last three lead to misses or a page 0 mapping
   localparam logic [19:0] VPNS [8] = '{20'h10000, 20'h21001, 20'h00002, 20'h33003,
                                        20'h44004, 20'h55005, 20'h66000, 20'h00007};

   logic clk, rst_n, p_ce, cmt_req_valid, msr_psr_dmme, msr_psr_rm;
   lsu_opc_t    cmt_lsu_opc_bus;
   logic [31:0] cmt_lsa, cmt_wdat, msr_dmm_tlbl_nxt, msr_dmm_tlbh_nxt;
   logic [2:0]  msr_dmm_tlbl_idx, msr_dmm_tlbh_idx;
   logic        msr_dmm_tlbl_we, msr_dmm_tlbh_we;
   logic        lsu_edtm, lsu_edpf, lsu_ealign, lsu_wb_valid;
   logic [31:0] lsu_vaddr, lsu_wb_dout;

   integer      seed = 67691;
   int          errors, n_issued, n_results, total;
   exp_t        exp_q [$];
   logic [31:0] mem_m [`LSU_MEM_DEPTH];
   logic [31:0] tlb_lo_m [8];
   logic [31:0] tlb_hi_m [8];

   lsu_top i_dut (
      .clk, .rst_n, .p_ce_s1(p_ce), .p_ce_s2(p_ce), .p_ce_s3(p_ce), .cmt_req_valid,
      .cmt_lsu_opc_bus, .cmt_lsa, .cmt_wdat, .lsu_edtm, .lsu_edpf, .lsu_ealign,
      .lsu_vaddr, .lsu_wb_dout, .lsu_wb_valid, .msr_psr_dmme, .msr_psr_rm,
      .msr_dmm_tlbl_idx, .msr_dmm_tlbl_nxt, .msr_dmm_tlbl_we,
      .msr_dmm_tlbh_idx, .msr_dmm_tlbh_nxt, .msr_dmm_tlbh_we
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         errors++;
         $display("[FAIL] %s: got %h, expected %h", name, got, want);
      end
   endtask

   // Expected result from the decode, translation and extension rules
   task automatic model(input logic ld, input logic sx, input lsu_size_e sz,
                        input logic [31:0] addr, input logic [31:0] data);
      exp_t        e;
      logic [19:0] vpn;
      logic [19:0] ppn;
      logic [2:0]  idx;
      logic [1:0]  ln;
      logic [11:0] widx;
      logic [31:0] w;
      logic [15:0] h;
      logic [7:0]  b;
      logic        hit;
      vpn      = addr[31:12];
      ln       = addr[1:0];
      idx      = vpn[2:0];
      e        = '0;
      e.vaddr  = addr;
      e.ealign = (sz == LSU_SIZE_HALF && ln[0]) || (sz == LSU_SIZE_WORD && ln != 2'b00);
      ppn      = vpn;
      if (msr_psr_dmme) begin
         hit    = tlb_lo_m[idx][0] && tlb_lo_m[idx][31:12] == vpn;
         ppn    = tlb_hi_m[idx][31:12];
         e.edtm = !hit;
         e.edpf = hit && ((!ld && !tlb_hi_m[idx][0]) || (!msr_psr_rm && !tlb_hi_m[idx][1]));
      end
      widx = {ppn[1:0], addr[11:2]};   // Physical word, upper ppn bits alias
      w    = mem_m[widx];
      if (!(e.edtm || e.edpf || e.ealign)) begin
         if (ld) begin
            h          = ln[1] ? w[31:16] : w[15:0];
            b          = w[8*ln +: 8];
            e.chk_dout = 1'b1;
            case (sz)
               LSU_SIZE_WORD: e.dout = w;
               LSU_SIZE_HALF: e.dout = sx ? 32'($signed(h)) : 32'(h);
               default:       e.dout = sx ? 32'($signed(b)) : 32'(b);
            endcase
         end else begin
            for (int k = 0; k < 4; k++) begin
               if (sz == LSU_SIZE_WORD || k[1:0] == ln ||
                   (sz == LSU_SIZE_HALF && k[1] == ln[1])) begin
                  w[8*k +: 8] = (sz == LSU_SIZE_WORD) ? data[8*k +: 8] :
                                (sz == LSU_SIZE_HALF) ? data[8*(k%2) +: 8] : data[7:0];
               end
            end
            mem_m[widx] = w;
         end
      end
      exp_q.push_back(e);
      n_issued++;
   endtask

   // Holds the request until a cycle with the enables high samples it
   task automatic issue(input logic ld, input logic sx, input lsu_size_e sz,
                        input logic [31:0] addr, input logic [31:0] data);
      logic go;
      go = 1'b0;
      while (!go) begin
         @(posedge clk);
         go = ($random(seed) & 3) != 0;   // High 75% of the time
         p_ce            <= go;
         cmt_req_valid   <= 1'b1;
         cmt_lsu_opc_bus <= '{load: ld, store: ~ld, sign_ext: sx, size: sz};
         cmt_lsa         <= addr;
         cmt_wdat        <= data;
      end
      model(ld, sx, sz, addr, data);
   endtask

   task automatic drain();
      @(posedge clk);
      p_ce          <= 1'b1;
      cmt_req_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
   endtask

   task automatic tlb_write(input logic [19:0] vpn, input logic [19:0] ppn,
                            input logic usr, input logic wr);
      @(posedge clk);
      msr_dmm_tlbl_idx <= vpn[2:0];
      msr_dmm_tlbl_nxt <= {vpn, 11'h0, 1'b1};
      msr_dmm_tlbl_we  <= 1'b1;
      msr_dmm_tlbh_idx <= vpn[2:0];
      msr_dmm_tlbh_nxt <= {ppn, 10'h0, usr, wr};
      msr_dmm_tlbh_we  <= 1'b1;
      tlb_lo_m[vpn[2:0]] = {vpn, 11'h0, 1'b1};
      tlb_hi_m[vpn[2:0]] = {ppn, 10'h0, usr, wr};
      @(posedge clk);
      msr_dmm_tlbl_we <= 1'b0;
      msr_dmm_tlbh_we <= 1'b0;
   endtask

   // Random aligned access within the initialized window of each page
   task automatic random_access(input int n, input logic mapped);
      logic [31:0] r;
      logic [19:0] vpn;
      logic [1:0]  lane;
      lsu_size_e   sz;
      for (int i = 0; i < n; i++) begin
         r    = $random(seed);
         sz   = (r[3:2] == 2'd3) ? LSU_SIZE_WORD : lsu_size_e'(r[3:2]);
         vpn  = mapped ? VPNS[r[6:4]] : {18'h0, r[5:4]};
         lane = (sz == LSU_SIZE_WORD) ? 2'b00 :
                (sz == LSU_SIZE_HALF) ? {r[14], 1'b0} : r[15:14];
         issue(r[0], r[1], sz, {vpn, 4'h0, r[13:8], lane}, $random(seed));
      end
   endtask

   always @(negedge clk) begin : scoreboard
      exp_t e;
      if (rst_n && lsu_wb_valid) begin
         n_results++;
         if (!p_ce) begin
            errors++;
            $display("lsu_wb_valid was high while p_ce_s3 was low");
         end
         if (exp_q.size() == 0) begin
            errors++;
            $display("lsu_wb_valid was high with no request outstanding");
         end else begin
            e = exp_q.pop_front();
            check("lsu_edtm", 32'(lsu_edtm), 32'(e.edtm));
            check("lsu_edpf", 32'(lsu_edpf), 32'(e.edpf));
            check("lsu_ealign", 32'(lsu_ealign), 32'(e.ealign));
            check("lsu_vaddr", lsu_vaddr, e.vaddr);
            if (e.chk_dout) check("lsu_wb_dout", lsu_wb_dout, e.dout);
         end
      end
   end

   initial begin
      repeat (N_REQ * 20) @(posedge clk);
      $display("Timeout after %0d cycles, results still missing", N_REQ * 20);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] r;
      logic [31:0] base;
      rst_n = 1'b0;
      p_ce = 1'b1;   // Stage registers fill with defined values during reset
      cmt_req_valid = 1'b0;
      cmt_lsu_opc_bus = '0;
      cmt_lsa = '0;
      cmt_wdat = '0;
      msr_psr_dmme = 1'b0;
      msr_psr_rm = 1'b1;
      msr_dmm_tlbl_idx = '0;
      msr_dmm_tlbl_nxt = '0;
      msr_dmm_tlbl_we = 1'b0;
      msr_dmm_tlbh_idx = '0;
      msr_dmm_tlbh_nxt = '0;
      msr_dmm_tlbh_we = 1'b0;
      for (int i = 0; i < 8; i++) begin
         tlb_lo_m[i] = '0;
         tlb_hi_m[i] = '0;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // Fill 64 words in each of pages 0 to 3, identity mapped
      for (int i = 0; i < N_INIT; i++) begin
         issue(1'b0, 1'b0, LSU_SIZE_WORD, {18'h0, i[7:6], 4'h0, i[5:0], 2'b00},
               32'h5A5A0000 ^ (i * 32'h9E3779B1));
      end
      random_access(300, 1'b0);

      for (int i = 0; i < N_MIS; i++) begin
         r    = $random(seed);
         base = {18'h0, r[1:0], 4'h0, r[7:2], 2'b00};
         if (r[8]) issue(r[11], 1'b0, LSU_SIZE_HALF, base | {30'h0, r[9], 1'b1}, $random(seed));
         else issue(r[11], 1'b0, LSU_SIZE_WORD, base | ((r[10:9] == 2'b00) ? 32'h1 : 32'(r[10:9])),
                    $random(seed));
         issue(1'b1, 1'b0, LSU_SIZE_WORD, base, '0);   // Word must be unchanged
      end

      drain();
      tlb_write(VPNS[0], 20'h00002, 1'b1, 1'b1);
      tlb_write(VPNS[1], 20'h7F002, 1'b1, 1'b1);   // Aliases physical page 2
      tlb_write(VPNS[2], 20'h00002, 1'b1, 1'b1);
      tlb_write(VPNS[3], 20'h00001, 1'b1, 1'b0);   // Read only
      tlb_write(VPNS[4], 20'h00003, 1'b0, 1'b1);   // Supervisor page
      tlb_write(VPNS[7], 20'h00000, 1'b1, 1'b1);
      msr_psr_dmme <= 1'b1;
      random_access(300, 1'b1);
      drain();
      msr_psr_rm <= 1'b0;
      random_access(200, 1'b1);
      drain();
      msr_psr_dmme <= 1'b0;
      msr_psr_rm   <= 1'b1;
      random_access(200, 1'b0);
      drain();

      total = errors;
      if (n_issued != n_results) begin
         total++;
         $display("%0d requests were issued but %0d results came back", n_issued, n_results);
      end
      $display("Finished with %0d errors over %0d requests", total, n_issued);
      if (total == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/lsu_tb_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_chk (
   input wire        clk,
   input wire        rst_n,
   input wire        p_ce_s2,
   input wire        p_ce_s3,
   input wire        lsu_wb_valid,
   input wire        lsu_edtm,
   input wire        lsu_edpf,
   input wire        lsu_ealign,
   input wire [31:0] lsu_vaddr
);

   wb_needs_s3: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_wb_valid |-> p_ce_s3)
      else $error("lsu_wb_valid high while p_ce_s3 is low");

   // A miss never comes with a permission fault
   miss_or_fault: assert property (@(posedge clk) disable iff (!rst_n)
      !(lsu_edtm && lsu_edpf))
      else $error("lsu_edtm and lsu_edpf high together");

   vaddr_held: assert property (@(posedge clk) disable iff (!rst_n)
      !p_ce_s2 |=> $stable(lsu_vaddr))
      else $error("lsu_vaddr changed while stage 2 was stalled");

   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> !(lsu_wb_valid || lsu_edtm || lsu_edpf || lsu_ealign))
      else $error("Outputs active during reset");

endmodule

bind lsu_top lsu_tb_chk i_chk (
   .clk, .rst_n, .p_ce_s2, .p_ce_s3, .lsu_wb_valid,
   .lsu_edtm, .lsu_edpf, .lsu_ealign, .lsu_vaddr
);

`default_nettype wire

// ==== lsu_top.f ====
+incdir+rtl
rtl/lsu_mmu_pkg.sv
rtl/lsu_op_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_dtlb.sv
rtl/lsu_dmem.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
dv/lsu_tb_chk.sv
dv/lsu_tb.sv

// ==== rtl/lsu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_decode (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         p_ce_s1,
   input  wire                         cmt_req_valid,
   input  wire lsu_op_pkg::lsu_opc_t   cmt_lsu_opc_bus,
   input  wire [`LSU_DW-1:0]           cmt_lsa,
   input  wire [`LSU_DW-1:0]           cmt_wdat,
   output lsu_op_pkg::lsu_req_t        s1_req
);
   import lsu_op_pkg::*;
   import lsu_mmu_pkg::*;

   lsu_vaddr_u s1i_vaddr;
   lsu_req_t   s1i_req;
   lsu_req_t   s1_pld;
   logic       s1_valid;
   logic       s1_ealign;

   assign s1i_vaddr = cmt_lsa;

   always_comb begin
      s1i_req          = '0;
      s1i_req.load     = cmt_lsu_opc_bus.load;
      s1i_req.store    = cmt_lsu_opc_bus.store;
      s1i_req.sign_ext = cmt_lsu_opc_bus.sign_ext;
      s1i_req.size     = cmt_lsu_opc_bus.size;
      s1i_req.valid    = cmt_req_valid & (cmt_lsu_opc_bus.load | cmt_lsu_opc_bus.store);
      s1i_req.vaddr    = s1i_vaddr;

      case (cmt_lsu_opc_bus.size)
         LSU_SIZE_WORD: begin
            s1i_req.wmsk   = 4'b1111;
            s1i_req.wdat   = cmt_wdat;
            s1i_req.ealign = |s1i_vaddr.wd.lane;
         end
         LSU_SIZE_HALF: begin
            // Low or high half-word by bit 1
            s1i_req.wmsk   = s1i_vaddr.wd.lane[1] ? 4'b1100 : 4'b0011;
            s1i_req.wdat   = {2{cmt_wdat[15:0]}};
            s1i_req.ealign = s1i_vaddr.wd.lane[0];
         end
         default: begin
            s1i_req.wmsk   = 4'b0001 << s1i_vaddr.wd.lane;   // One-hot lane
            s1i_req.wdat   = {4{cmt_wdat[7:0]}};
         end
      endcase

      if (!cmt_lsu_opc_bus.store) begin
         s1i_req.wmsk = '0;
      end
   end

   // Control bits of stage 1
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         s1_ealign <= 1'b0;
      end else if (p_ce_s1) begin
         s1_valid  <= s1i_req.valid;
         s1_ealign <= s1i_req.ealign;
      end
   end

   always_ff @(posedge clk) begin
      if (p_ce_s1) begin
         s1_pld <= s1i_req;
      end
   end

   always_comb begin
      s1_req        = s1_pld;
      s1_req.valid  = s1_valid;
      s1_req.ealign = s1_ealign;
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_dmem (
   input  wire                         clk,
   input  wire                         p_ce_s2,
   input  wire                         access,
   input  wire [`LSU_MEM_IDX_BITS-1:0] widx,
   input  wire [`LSU_DW/8-1:0]         wmsk,
   input  wire [`LSU_DW-1:0]           wdat,
   output logic [`LSU_DW-1:0]          rdata
);

   logic [`LSU_DW-1:0] mem [`LSU_MEM_DEPTH];
   logic               mem_en;
   logic               mem_wr;

   // Fires once per request, on its stage-2 edge
   assign mem_en = access & p_ce_s2;
   assign mem_wr = |wmsk;   // Loads carry an empty mask

   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_wr) begin
            for (int b = 0; b < `LSU_DW/8; b++) begin
               if (wmsk[b]) begin
                  mem[widx][b*8 +: 8] <= wdat[b*8 +: 8];
               end
            end
         end else begin
            rdata <= mem[widx];
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_dtlb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_dtlb (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire lsu_op_pkg::lsu_req_t      s1_req,
   input  wire                            msr_psr_dmme,
   input  wire                            msr_psr_rm,
   input  wire [`LSU_TLB_IDX_BITS-1:0]    msr_dmm_tlbl_idx,
   input  wire [`LSU_DW-1:0]              msr_dmm_tlbl_nxt,
   input  wire                            msr_dmm_tlbl_we,
   input  wire [`LSU_TLB_IDX_BITS-1:0]    msr_dmm_tlbh_idx,
   input  wire [`LSU_DW-1:0]              msr_dmm_tlbh_nxt,
   input  wire                            msr_dmm_tlbh_we,
   output lsu_mmu_pkg::dtlb_xlate_t       xlate
);
   import lsu_mmu_pkg::*;

   dtlb_lo_t                        tlb_lo [`LSU_TLB_DEPTH];
   dtlb_hi_t                        tlb_hi [`LSU_TLB_DEPTH];

   logic [`LSU_VPN_BITS-1:0]        req_vpn;
   logic [`LSU_TLB_IDX_BITS-1:0]    tlb_idx;
   dtlb_lo_t                        sel_lo;
   dtlb_hi_t                        sel_hi;
   logic                            tlb_hit;
   logic                            perm_fault;

   // Low word holds the valid bit, so only it is cleared
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `LSU_TLB_DEPTH; i++) begin
            tlb_lo[i] <= '0;
         end
      end else if (msr_dmm_tlbl_we) begin
         tlb_lo[msr_dmm_tlbl_idx] <= msr_dmm_tlbl_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (msr_dmm_tlbh_we) begin
         tlb_hi[msr_dmm_tlbh_idx] <= msr_dmm_tlbh_nxt;
      end
   end

   assign req_vpn = s1_req.vaddr.pg.vpn;
   assign tlb_idx = req_vpn[`LSU_TLB_IDX_BITS-1:0];   // Direct mapped
   assign sel_lo  = tlb_lo[tlb_idx];
   assign sel_hi  = tlb_hi[tlb_idx];

   // Full vpn compared as tag
   assign tlb_hit = sel_lo.valid & (sel_lo.vpn == req_vpn);

   // Store to read-only page, or supervisor page from user mode
   assign perm_fault = (s1_req.store & ~sel_hi.writable) |
                       (~msr_psr_rm & ~sel_hi.user);

   always_comb begin
      if (!msr_psr_dmme) begin
         // Identity mapping with MMU off
         xlate.ppn  = req_vpn;
         xlate.edtm = 1'b0;
         xlate.edpf = 1'b0;
         xlate.hit  = 1'b1;
      end else begin
         xlate.ppn  = sel_hi.ppn;
         xlate.edtm = ~tlb_hit;
         xlate.edpf = tlb_hit & perm_fault;
         xlate.hit  = tlb_hit;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Datapath and virtual address width
`define LSU_DW            32

// Byte lane select within a word
`define LSU_LANE_BITS     2

// 4 KB pages
`define LSU_PAGE_BITS     12
`define LSU_VPN_BITS      (`LSU_DW - `LSU_PAGE_BITS)

// Direct-mapped DTLB, 8 entries
`define LSU_TLB_IDX_BITS  3
`define LSU_TLB_DEPTH     (1 << `LSU_TLB_IDX_BITS)

// Local data memory, 4096 words = 16 KB
`define LSU_MEM_IDX_BITS  12
`define LSU_MEM_DEPTH     (1 << `LSU_MEM_IDX_BITS)

`endif

// ==== rtl/lsu_mmu_pkg.sv ====
`default_nettype none
`include "lsu_macros.svh"

package lsu_mmu_pkg;

   // Virtual address seen as page number plus page offset
   typedef struct packed {
      logic [`LSU_VPN_BITS-1:0]   vpn;
      logic [`LSU_PAGE_BITS-1:0]  offset;
   } lsu_vaddr_page_t;

   // Same address seen as word index plus byte lane
   typedef struct packed {
      logic [`LSU_DW-`LSU_LANE_BITS-1:0] word;
      logic [`LSU_LANE_BITS-1:0]         lane;
   } lsu_vaddr_word_t;

   typedef union packed {
      lsu_vaddr_page_t pg;
      lsu_vaddr_word_t wd;
   } lsu_vaddr_u;

   // DTLB low word, tag side
   typedef struct packed {
      logic [`LSU_VPN_BITS-1:0]   vpn;
      logic [`LSU_PAGE_BITS-2:0]  rsv;
      logic                       valid;
   } dtlb_lo_t;

   // DTLB high word, translation and permissions
   typedef struct packed {
      logic [`LSU_VPN_BITS-1:0]   ppn;
      logic [`LSU_PAGE_BITS-3:0]  rsv;
      logic                       user;
      logic                       writable;
   } dtlb_hi_t;

   typedef struct packed {
      logic [`LSU_VPN_BITS-1:0]   ppn;
      logic                       edtm;   // TLB miss
      logic                       edpf;   // Page fault
      logic                       hit;
   } dtlb_xlate_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_op_pkg.sv ====
`default_nettype none
`include "lsu_macros.svh"

package lsu_op_pkg;

   typedef enum logic [1:0] {
      LSU_SIZE_BYTE = 2'd0,
      LSU_SIZE_HALF = 2'd1,
      LSU_SIZE_WORD = 2'd2
   } lsu_size_e;

   // Operation field from the commit stage
   typedef struct packed {
      logic       load;
      logic       store;
      logic       sign_ext;
      lsu_size_e  size;
   } lsu_opc_t;

   typedef struct packed {
      logic edtm;
      logic edpf;
      logic ealign;
   } lsu_exc_t;

   // Decoded request held in stage 1
   typedef struct packed {
      logic                       valid;
      logic                       load;
      logic                       store;
      logic                       sign_ext;
      lsu_size_e                  size;
      lsu_mmu_pkg::lsu_vaddr_u    vaddr;
      logic [`LSU_DW/8-1:0]       wmsk;   // Zero for loads
      logic [`LSU_DW-1:0]         wdat;   // Replicated across lanes
      logic                       ealign;
   } lsu_req_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_result.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_result (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            p_ce_s2,
   input  wire                            p_ce_s3,
   input  wire lsu_op_pkg::lsu_req_t      s1_req,
   input  wire lsu_mmu_pkg::dtlb_xlate_t  xlate,
   input  wire [`LSU_DW-1:0]              rdata,
   output logic                           lsu_edtm,
   output logic                           lsu_edpf,
   output logic                           lsu_ealign,
   output logic [`LSU_DW-1:0]             lsu_vaddr,
   output logic [`LSU_DW-1:0]             lsu_wb_dout,
   output logic                           lsu_wb_valid
);
   import lsu_op_pkg::*;
   import lsu_mmu_pkg::*;

   lsu_exc_t      s2i_exc;
   logic          s2_valid;
   lsu_exc_t      s2_exc;
   lsu_vaddr_u    s2_vaddr;
   lsu_size_e     s2_size;
   logic          s2_sign_ext;
   logic [7:0]    dout_8b;
   logic [15:0]   dout_16b;

   assign s2i_exc = '{edtm: xlate.edtm, edpf: xlate.edpf, ealign: s1_req.ealign};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s2_valid <= 1'b0;
         s2_exc   <= '0;
      end else if (p_ce_s2) begin
         s2_valid <= s1_req.valid;
         s2_exc   <= s2i_exc;
      end
   end

   always_ff @(posedge clk) begin
      if (p_ce_s2) begin
         s2_vaddr    <= s1_req.vaddr;
         s2_size     <= s1_req.size;
         s2_sign_ext <= s1_req.sign_ext;
      end
   end

   // Byte and half-word pick by lane
   assign dout_8b  = rdata[{s2_vaddr.wd.lane, 3'b000} +: 8];
   assign dout_16b = s2_vaddr.wd.lane[1] ? rdata[31:16] : rdata[15:0];

   always_comb begin
      case (s2_size)
         LSU_SIZE_WORD: lsu_wb_dout = rdata;
         LSU_SIZE_HALF: lsu_wb_dout = {{16{s2_sign_ext & dout_16b[15]}}, dout_16b};
         default:       lsu_wb_dout = {{24{s2_sign_ext & dout_8b[7]}}, dout_8b};
      endcase
   end

   assign lsu_edtm     = s2_valid & s2_exc.edtm;
   assign lsu_edpf     = s2_valid & s2_exc.edpf;
   assign lsu_ealign   = s2_valid & s2_exc.ealign;
   assign lsu_vaddr    = s2_vaddr;
   assign lsu_wb_valid = s2_valid & p_ce_s3;   // Handed to writeback only when s3 moves

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_top (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         p_ce_s1,
   input  wire                         p_ce_s2,
   input  wire                         p_ce_s3,
   input  wire                         cmt_req_valid,
   input  wire lsu_op_pkg::lsu_opc_t   cmt_lsu_opc_bus,
   input  wire [`LSU_DW-1:0]           cmt_lsa,
   input  wire [`LSU_DW-1:0]           cmt_wdat,
   output logic                        lsu_edtm,
   output logic                        lsu_edpf,
   output logic                        lsu_ealign,
   output logic [`LSU_DW-1:0]          lsu_vaddr,
   output logic [`LSU_DW-1:0]          lsu_wb_dout,
   output logic                        lsu_wb_valid,
   input  wire                         msr_psr_dmme,
   input  wire                         msr_psr_rm,
   input  wire [`LSU_TLB_IDX_BITS-1:0] msr_dmm_tlbl_idx,
   input  wire [`LSU_DW-1:0]           msr_dmm_tlbl_nxt,
   input  wire                         msr_dmm_tlbl_we,
   input  wire [`LSU_TLB_IDX_BITS-1:0] msr_dmm_tlbh_idx,
   input  wire [`LSU_DW-1:0]           msr_dmm_tlbh_nxt,
   input  wire                         msr_dmm_tlbh_we
);
   import lsu_op_pkg::*;
   import lsu_mmu_pkg::*;

   lsu_req_t                        s1_req;
   dtlb_xlate_t                     xlate;
   logic [`LSU_DW-1:0]              rdata;
   logic [`LSU_DW-1:0]              paddr;
   logic [`LSU_MEM_IDX_BITS-1:0]    mem_widx;
   logic                            mem_access;

   lsu_decode u_decode (
      .clk, .rst_n, .p_ce_s1, .cmt_req_valid, .cmt_lsu_opc_bus, .cmt_lsa, .cmt_wdat,
      .s1_req
   );

   lsu_dtlb u_dtlb (
      .clk, .rst_n, .s1_req, .msr_psr_dmme, .msr_psr_rm,
      .msr_dmm_tlbl_idx, .msr_dmm_tlbl_nxt, .msr_dmm_tlbl_we,
      .msr_dmm_tlbh_idx, .msr_dmm_tlbh_nxt, .msr_dmm_tlbh_we,
      .xlate
   );

   // Upper ppn bits alias onto the 16 KB memory
   assign paddr      = {xlate.ppn, s1_req.vaddr.pg.offset};
   assign mem_widx   = paddr[`LSU_MEM_IDX_BITS+`LSU_LANE_BITS-1:`LSU_LANE_BITS];
   assign mem_access = s1_req.valid & ~xlate.edtm & ~xlate.edpf & ~s1_req.ealign;

   lsu_dmem u_dmem (
      .clk, .p_ce_s2, .access(mem_access), .widx(mem_widx),
      .wmsk(s1_req.wmsk), .wdat(s1_req.wdat), .rdata
   );

   lsu_result u_result (
      .clk, .rst_n, .p_ce_s2, .p_ce_s3, .s1_req, .xlate, .rdata,
      .lsu_edtm, .lsu_edpf, .lsu_ealign, .lsu_vaddr, .lsu_wb_dout, .lsu_wb_valid
   );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass line shows up
verilator --binary --timing --timescale 1ns/1ps --top-module lsu_tb \
   -f lsu_top.f -o lsu_sim || exit 1
out=$(./obj_dir/lsu_sim) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
